// File: source/a800_macros.svh
`ifndef A800_MACROS_SVH
`define A800_MACROS_SVH

// ====================
// Sector buffer
// ====================

// 512-byte sector, byte addressed
`define A800_SECTOR_AW 9

// ====================
// Drive slots
// ====================

`define A800_DRIVES 8

// Slots 4 and 5 hold executable and cartridge images, never writable
`define A800_RO_DRIVES 8'h30

// ====================
// Mouse to paddle
// ====================

// Largest movement accepted from one packet
`define A800_DELTA_LIMIT (10)

`define A800_AXIS_MIN (-128)
`define A800_AXIS_MAX (127)

`endif

// File: source/a800_pkg.sv
`include "a800_macros.svh"

package a800_pkg;

	// ====================
	// Control processor side
	// ====================

	// Command word, lba_sel sits in bit 0
	typedef struct packed {
		logic [2:0] drv_num;
		logic       block_wr;
		logic       block_rd;
		logic       lba_sel;
	} host_ctrl_t;

	typedef struct packed {
		logic [23:0] pad;
		logic [7:0]  data;
	} host_byte_t;

	// Data word is a sector number or a buffer byte, chosen by lba_sel
	typedef union packed {
		logic [31:0] lba;
		host_byte_t  bytes;
	} host_word_u;

	typedef struct packed {
		logic       readonly;
		logic [1:0] filetype;
		logic [2:0] fileno;
		logic       mounted;
		logic       io_done;
	} host_status_t;

	// ====================
	// Host SD side
	// ====================

	typedef struct packed {
		logic [`A800_DRIVES-1:0] img_mounted;
		logic                    readonly;
		logic [1:0]              filetype;
		logic [31:0]             size;
	} mount_info_t;

	typedef struct packed {
		logic [31:0]             lba;
		logic [`A800_DRIVES-1:0] rd;
		logic [`A800_DRIVES-1:0] wr;
	} sd_req_t;

	// ====================
	// Mouse and paddles
	// ====================

	// PS/2 packet, flags bit 0 left, bit 1 right, bit 4 X sign, bit 5 Y sign
	typedef struct packed {
		logic       toggle;
		logic [7:0] dy;
		logic [7:0] dx;
		logic [7:0] flags;
	} mouse_pkt_t;

	// X in the low byte, same as the analog stick word
	typedef struct packed {
		logic signed [7:0] y;
		logic signed [7:0] x;
	} axis_t;

endpackage

// File: source/sector_buffer.sv
`include "a800_macros.svh"

module sector_buffer (
	input  logic                       clk_sys,

	// Port A, host SD transfer
	input  logic [`A800_SECTOR_AW-1:0] a_addr_i,
	input  logic [7:0]                 a_wdata_i,
	input  logic                       a_we_i,
	output logic [7:0]                 a_rdata_o,

	// Port B, control processor bridge
	input  logic [`A800_SECTOR_AW-1:0] b_addr_i,
	input  logic [7:0]                 b_wdata_i,
	input  logic                       b_we_i,
	output logic [7:0]                 b_rdata_o
);

	localparam int DEPTH = 1 << `A800_SECTOR_AW;

	logic [7:0] mem [DEPTH];

	// Both ports read old data on a same-cycle write
	always_ff @(posedge clk_sys) begin
		a_rdata_o <= mem[a_addr_i];
		b_rdata_o <= mem[b_addr_i];
	end

	// Port B wins if both ports write one address together
	always_ff @(posedge clk_sys) begin
		if (a_we_i) begin
			mem[a_addr_i] <= a_wdata_i;
		end
		if (b_we_i) begin
			mem[b_addr_i] <= b_wdata_i;
		end
	end

endmodule

// File: source/disk_bridge.sv
`include "a800_macros.svh"

module disk_bridge
	import a800_pkg::*;
(
	input  logic                       clk_sys,
	input  logic                       areset,

	// Control processor registers and strobes
	input  host_ctrl_t                 host_ctrl_i,
	input  host_word_u                 host_wdata_i,
	input  logic                       data_wr_i,
	input  logic                       data_rd_i,
	input  logic                       io_wr_i,
	output logic [31:0]                host_rdata_o,
	output host_status_t               host_status_o,

	// Host SD block interface
	input  mount_info_t                mount_i,
	input  logic [`A800_DRIVES-1:0]    sd_ack_i,
	output sd_req_t                    sd_req_o,

	// Sector buffer port B
	output logic [`A800_SECTOR_AW-1:0] buf_addr_o,
	output logic [7:0]                 buf_wdata_o,
	output logic                       buf_we_o,
	input  logic [7:0]                 buf_rdata_i
);

	// Two registered copies of every strobe
	logic wr_q1, wr_q2;
	logic rd_q1, rd_q2;
	logic brd_q1, brd_q2;
	logic bwr_q1, bwr_q2;
	logic ack_q1, ack_q2;
	logic mnt_q1, mnt_q2;

	logic wr_rise, rd_fall, brd_rise, bwr_rise, ack_fall, mnt_rise;

	logic lba_ld;
	logic inc_pend;

	logic        io_done;
	logic        mounted;
	logic [2:0]  fileno;
	logic [1:0]  filetype;
	logic        readonly;
	logic [31:0] file_size;
	logic [2:0]  mnt_fileno;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			{wr_q1, wr_q2, rd_q1, rd_q2} <= '0;
			{brd_q1, brd_q2, bwr_q1, bwr_q2} <= '0;
			{ack_q1, ack_q2, mnt_q1, mnt_q2} <= '0;
		end else begin
			wr_q1  <= data_wr_i;
			wr_q2  <= wr_q1;
			rd_q1  <= data_rd_i;
			rd_q2  <= rd_q1;
			brd_q1 <= host_ctrl_i.block_rd;
			brd_q2 <= brd_q1;
			bwr_q1 <= host_ctrl_i.block_wr;
			bwr_q2 <= bwr_q1;
			ack_q1 <= |sd_ack_i;
			ack_q2 <= ack_q1;
			mnt_q1 <= |mount_i.img_mounted;
			mnt_q2 <= mnt_q1;
		end
	end

	assign wr_rise  = wr_q1 & ~wr_q2;
	assign rd_fall  = rd_q2 & ~rd_q1;
	assign brd_rise = brd_q1 & ~brd_q2;
	assign bwr_rise = bwr_q1 & ~bwr_q2;
	assign ack_fall = ack_q2 & ~ack_q1;
	assign mnt_rise = mnt_q1 & ~mnt_q2;

	// ====================
	// Buffer access
	// ====================

	// Write strobe becomes an LBA load or a byte write one edge later
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			lba_ld   <= 1'b0;
			buf_we_o <= 1'b0;
			inc_pend <= 1'b0;
		end else begin
			lba_ld   <= wr_rise & host_ctrl_i.lba_sel;
			buf_we_o <= wr_rise & ~host_ctrl_i.lba_sel;
			inc_pend <= buf_we_o;
		end
	end

	always_ff @(posedge clk_sys) begin
		buf_wdata_o <= host_wdata_i.bytes.data;
	end

	// Clear from io_wr wins over both increments
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			buf_addr_o <= '0;
		end else if (io_wr_i) begin
			buf_addr_o <= '0;
		end else if (inc_pend || rd_fall) begin
			buf_addr_o <= buf_addr_o + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (host_ctrl_i.lba_sel) begin
			host_rdata_o <= file_size;
		end else begin
			host_rdata_o <= {24'd0, buf_rdata_i};
		end
	end

	// ====================
	// Block requests
	// ====================

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			sd_req_o <= '0;
			io_done  <= 1'b0;
		end else begin
			if (lba_ld) begin
				sd_req_o.lba <= host_wdata_i.lba;
			end
			if (brd_rise) begin
				sd_req_o.rd[host_ctrl_i.drv_num] <= 1'b1;
				io_done <= 1'b0;
			end
			if (bwr_rise) begin
				sd_req_o.wr[host_ctrl_i.drv_num] <= 1'b1;
				io_done <= 1'b0;
			end
			// Host took the request
			if (|sd_ack_i) begin
				sd_req_o.rd <= '0;
				sd_req_o.wr <= '0;
			end
			if (ack_fall) begin
				io_done <= 1'b1;
			end
		end
	end

	// ====================
	// Image mount
	// ====================

	// Highest mounted slot
	always_comb begin
		mnt_fileno = '0;
		for (int i = 0; i < `A800_DRIVES; i++) begin
			if (mount_i.img_mounted[i]) begin
				mnt_fileno = 3'(i);
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			mounted  <= 1'b0;
			fileno   <= '0;
			filetype <= '0;
			readonly <= 1'b0;
		end else if (mnt_rise) begin
			mounted  <= ~mounted;
			fileno   <= mnt_fileno;
			filetype <= mount_i.filetype;
			readonly <= mount_i.readonly | (|(mount_i.img_mounted & `A800_RO_DRIVES));
		end
	end

	always_ff @(posedge clk_sys) begin
		if (mnt_rise) begin
			file_size <= mount_i.size;
		end
	end

	always_comb begin
		host_status_o.io_done  = io_done;
		host_status_o.mounted  = mounted;
		host_status_o.fileno   = fileno;
		host_status_o.filetype = filetype;
		host_status_o.readonly = readonly;
	end

endmodule

// File: source/mouse_axis.sv
`include "a800_macros.svh"

module mouse_axis
	import a800_pkg::*;
(
	input  logic        clk_sys,
	input  logic        areset,
	input  mouse_pkt_t  mouse_i,
	input  logic [15:0] analog_i,
	input  logic [13:0] joy_i,
	input  logic        cpu_halt_i,
	input  logic        invert_y_i,
	output axis_t       axis_o,
	output logic [13:0] joy_o
);

	logic tog_q1, tog_q2;
	logic new_pkt;
	logic emu;

	logic signed [7:0] mx, my;
	logic signed [8:0] dx, dy;
	logic signed [8:0] nx, ny;

	// Halve toward minus infinity, then limit the step
	function automatic logic signed [8:0] pkt_delta(input logic sign, input logic [7:0] mov);
		logic signed [8:0] d;
		d = {sign, sign, mov[7:1]};
		if (d > `A800_DELTA_LIMIT) begin
			return 9'(`A800_DELTA_LIMIT);
		end else if (d < -`A800_DELTA_LIMIT) begin
			return 9'(-`A800_DELTA_LIMIT);
		end
		return d;
	endfunction

	function automatic logic signed [7:0] sat_axis(input logic signed [8:0] v);
		if (v < `A800_AXIS_MIN) begin
			return 8'(`A800_AXIS_MIN);
		end else if (v > `A800_AXIS_MAX) begin
			return 8'(`A800_AXIS_MAX);
		end
		return v[7:0];
	endfunction

	// Toggle copies only follow the packet strobe
	always_ff @(posedge clk_sys) begin
		tog_q1 <= mouse_i.toggle;
		tog_q2 <= tog_q1;
	end

	assign new_pkt = tog_q1 ^ tog_q2;

	assign dx = pkt_delta(mouse_i.flags[4], mouse_i.dx);
	assign dy = pkt_delta(mouse_i.flags[5], mouse_i.dy);
	assign nx = mx + dx;
	assign ny = invert_y_i ? (my - dy) : (my + dy);

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			emu <= 1'b0;
			mx  <= '0;
			my  <= '0;
		end else begin
			if (new_pkt) begin
				emu <= 1'b1;
				mx  <= sat_axis(nx);
				my  <= sat_axis(ny);
			end
			// Real stick or halted CPU takes over
			if ((analog_i != '0) || cpu_halt_i) begin
				emu <= 1'b0;
				mx  <= '0;
				my  <= '0;
			end
		end
	end

	always_comb begin
		if (emu) begin
			axis_o.x = mx;
			axis_o.y = my;
			joy_o    = {joy_i[13:9], mouse_i.flags[1:0], joy_i[6:0]};
		end else begin
			axis_o = axis_t'(analog_i);
			joy_o  = joy_i;
		end
	end

endmodule

// File: source/a800_io_top.sv
`include "a800_macros.svh"

module a800_io_top
	import a800_pkg::*;
(
	input  logic                       clk_sys,
	input  logic                       areset,

	// Control processor
	input  host_ctrl_t                 host_ctrl_i,
	input  host_word_u                 host_wdata_i,
	input  logic                       data_wr_i,
	input  logic                       data_rd_i,
	input  logic                       io_wr_i,
	output logic [31:0]                host_rdata_o,
	output host_status_t               host_status_o,

	// Host SD
	input  mount_info_t                mount_i,
	input  logic [`A800_DRIVES-1:0]    sd_ack_i,
	output sd_req_t                    sd_req_o,
	input  logic [`A800_SECTOR_AW-1:0] sd_buf_addr_i,
	input  logic [7:0]                 sd_buf_wdata_i,
	input  logic                       sd_buf_we_i,
	output logic [7:0]                 sd_buf_rdata_o,

	// Mouse and joystick
	input  mouse_pkt_t                 mouse_i,
	input  logic [15:0]                analog_i,
	input  logic [13:0]                joy_i,
	input  logic                       cpu_halt_i,
	input  logic                       invert_y_i,
	output axis_t                      axis_o,
	output logic [13:0]                joy_o
);

	logic [`A800_SECTOR_AW-1:0] buf_addr;
	logic [7:0]                 buf_wdata;
	logic                       buf_we;
	logic [7:0]                 buf_rdata;

	disk_bridge u_disk_bridge (
		.clk_sys       (clk_sys),
		.areset        (areset),
		.host_ctrl_i   (host_ctrl_i),
		.host_wdata_i  (host_wdata_i),
		.data_wr_i     (data_wr_i),
		.data_rd_i     (data_rd_i),
		.io_wr_i       (io_wr_i),
		.host_rdata_o  (host_rdata_o),
		.host_status_o (host_status_o),
		.mount_i       (mount_i),
		.sd_ack_i      (sd_ack_i),
		.sd_req_o      (sd_req_o),
		.buf_addr_o    (buf_addr),
		.buf_wdata_o   (buf_wdata),
		.buf_we_o      (buf_we),
		.buf_rdata_i   (buf_rdata)
	);

	// Port A to the host, port B to the bridge
	sector_buffer u_sector_buffer (
		.clk_sys   (clk_sys),
		.a_addr_i  (sd_buf_addr_i),
		.a_wdata_i (sd_buf_wdata_i),
		.a_we_i    (sd_buf_we_i),
		.a_rdata_o (sd_buf_rdata_o),
		.b_addr_i  (buf_addr),
		.b_wdata_i (buf_wdata),
		.b_we_i    (buf_we),
		.b_rdata_o (buf_rdata)
	);

	mouse_axis u_mouse_axis (
		.clk_sys    (clk_sys),
		.areset     (areset),
		.mouse_i    (mouse_i),
		.analog_i   (analog_i),
		.joy_i      (joy_i),
		.cpu_halt_i (cpu_halt_i),
		.invert_y_i (invert_y_i),
		.axis_o     (axis_o),
		.joy_o      (joy_o)
	);

endmodule

// File: bench/a800_io_chk.sv
module a800_io_chk
	import a800_pkg::*;
(
	input logic         clk_sys,
	input logic         areset,
	input sd_req_t      sd_req_i,
	input host_status_t status_i
);

	timeunit 1ns;
	timeprecision 100ps;

	// Read back by the testbench for its closing count
	int assert_fails = 0;

	// Never a read and a write request pending together
	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (areset)
		!((|sd_req_i.rd) && (|sd_req_i.wr)))
	else begin
		assert_fails++;
		$error("read and write block requests pending together");
	end

	// One drive per request direction
	a_one_drive: assert property (@(posedge clk_sys) disable iff (areset)
		$onehot0(sd_req_i.rd) && $onehot0(sd_req_i.wr))
	else begin
		assert_fails++;
		$error("more than one drive bit set in a request mask");
	end

	a_reset_clear: assert property (@(posedge clk_sys)
		areset |=> (sd_req_i == '0) && (status_i == '0))
	else begin
		assert_fails++;
		$error("status or requests not cleared after reset");
	end

endmodule

// File: bench/tb_a800_io.sv
`include "a800_macros.svh"

module tb_a800_io
	import a800_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// Rough upper bound of all directed tests together
	localparam int TEST_CYCLES = 2000;
	localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

	logic clk_sys;
	logic areset;
	host_ctrl_t host_ctrl;
	host_word_u host_wdata;
	logic data_wr, data_rd, io_wr;
	logic [31:0] host_rdata;
	host_status_t host_status;
	mount_info_t mount;
	logic [7:0] sd_ack;
	sd_req_t sd_req;
	logic [`A800_SECTOR_AW-1:0] sd_buf_addr;
	logic [7:0] sd_buf_wdata, sd_buf_rdata;
	logic sd_buf_we;
	mouse_pkt_t mouse;
	logic [15:0] analog;
	logic [13:0] joy_in, joy_out;
	logic cpu_halt, invert_y;
	axis_t axis;

	int mismatches, failures, cycles;
	string test_name;
	host_status_t exp_st;
	logic [31:0] exp_lba;
	int exp_x, exp_y;
	logic [7:0] pattern [16];

	a800_io_top DUT (
		.clk_sys(clk_sys), .areset(areset),
		.host_ctrl_i(host_ctrl), .host_wdata_i(host_wdata),
		.data_wr_i(data_wr), .data_rd_i(data_rd), .io_wr_i(io_wr),
		.host_rdata_o(host_rdata), .host_status_o(host_status),
		.mount_i(mount), .sd_ack_i(sd_ack), .sd_req_o(sd_req),
		.sd_buf_addr_i(sd_buf_addr), .sd_buf_wdata_i(sd_buf_wdata),
		.sd_buf_we_i(sd_buf_we), .sd_buf_rdata_o(sd_buf_rdata),
		.mouse_i(mouse), .analog_i(analog), .joy_i(joy_in),
		.cpu_halt_i(cpu_halt), .invert_y_i(invert_y),
		.axis_o(axis), .joy_o(joy_out)
	);

	bind a800_io_top a800_io_chk u_a800_io_chk (
		.clk_sys(clk_sys), .areset(areset),
		.sd_req_i(sd_req_o), .status_i(host_status_o)
	);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			failures++;
			$display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
			$display("Closing: %0d mismatches, %0d other errors, %0d assertion failures",
				mismatches, failures, DUT.u_a800_io_chk.assert_fails);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// ====================
	// Compare tasks
	// ====================

	task automatic byte_compare(input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH %s: expected %h, actual %h", test_name, exp, act);
		end
	endtask

	task automatic word_compare(input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH %s: expected %h, actual %h", test_name, exp, act);
		end
	endtask

	task automatic status_compare(input host_status_t exp, input host_status_t act);
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH %s: expected status %h, actual %h", test_name, exp, act);
		end
	endtask

	task automatic req_compare(input sd_req_t exp, input sd_req_t act);
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH %s: expected request %h, actual %h", test_name, exp, act);
		end
	endtask

	task automatic axis_compare(input axis_t exp, input axis_t act);
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH %s: expected x %0d y %0d, actual x %0d y %0d",
				test_name, exp.x, exp.y, act.x, act.y);
		end
	endtask

	task automatic joy_compare(input logic [13:0] exp, input logic [13:0] act);
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH %s: expected joystick %h, actual %h", test_name, exp, act);
		end
	endtask

	// ====================
	// Helpers
	// ====================

	// Drive point sits 1 ns after the rising edge
	task automatic step(input int n = 1);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	function automatic sd_req_t req_value(input logic [31:0] lba, input logic [7:0] rd,
		input logic [7:0] wr);
		sd_req_t r;
		r.lba = lba;
		r.rd  = rd;
		r.wr  = wr;
		return r;
	endfunction

	// Write lands two edges after the strobe, address moves on one edge later
	task automatic host_write(input logic lba_sel, input logic [31:0] word);
		host_ctrl.lba_sel = lba_sel;
		host_wdata.lba = word;
		data_wr = 1'b1;
		step();
		data_wr = 1'b0;
		step(3);
	endtask

	task automatic pulse_io_wr();
		io_wr = 1'b1;
		step();
		io_wr = 1'b0;
	endtask

	task automatic wait_io_done();
		int waited;
		waited = 0;
		while (!host_status.io_done && waited < 8) begin
			step();
			waited++;
		end
		if (!host_status.io_done) begin
			failures++;
			$display("Error in %s: io_done did not rise after the acknowledge ended", test_name);
		end
	endtask

	// Sign and movement as a 9-bit value, halved toward minus infinity, then limited
	function automatic int movement_step(input logic sign, input logic [7:0] mov);
		int v;
		v = sign ? int'(mov) - 256 : int'(mov);
		v = v >>> 1;
		if (v > `A800_DELTA_LIMIT) v = `A800_DELTA_LIMIT;
		if (v < -`A800_DELTA_LIMIT) v = -`A800_DELTA_LIMIT;
		return v;
	endfunction

	function automatic int clamp_axis(input int v);
		if (v < `A800_AXIS_MIN) return `A800_AXIS_MIN;
		if (v > `A800_AXIS_MAX) return `A800_AXIS_MAX;
		return v;
	endfunction

	// ====================
	// Directed tests
	// ====================

	task automatic load_lba();
		test_name = "lba_load";
		exp_lba = $urandom;
		host_write(1'b1, exp_lba);
		step();
		req_compare(req_value(exp_lba, 8'h00, 8'h00), sd_req);
	endtask

	task automatic fill_from_host();
		test_name = "host_to_sd";
		host_ctrl = '0;
		pulse_io_wr();
		for (int i = 0; i < 16; i++) begin
			pattern[i] = 8'($urandom);
			host_write(1'b0, {24'd0, pattern[i]});
		end
		for (int i = 0; i < 16; i++) begin
			sd_buf_addr = `A800_SECTOR_AW'(i);
			step();
			byte_compare(pattern[i], sd_buf_rdata);
		end
	endtask

	task automatic fill_from_sd();
		test_name = "sd_to_host";
		for (int i = 0; i < 16; i++) begin
			pattern[i] = 8'($urandom);
			sd_buf_addr = `A800_SECTOR_AW'(i);
			sd_buf_wdata = pattern[i];
			sd_buf_we = 1'b1;
			step();
		end
		sd_buf_we = 1'b0;
		host_ctrl = '0;
		pulse_io_wr();
		// Registered RAM plus output register
		step(2);
		for (int i = 0; i < 16; i++) begin
			word_compare({24'd0, pattern[i]}, host_rdata);
			data_rd = 1'b1;
			step();
			data_rd = 1'b0;
			step(4);
		end
	endtask

	task automatic block_request(input logic is_wr, input logic [2:0] drv);
		logic [7:0] mask;
		mask = 8'h01 << drv;
		host_ctrl = '0;
		host_ctrl.drv_num = drv;
		host_ctrl.block_rd = ~is_wr;
		host_ctrl.block_wr = is_wr;
		step(2);
		exp_st.io_done = 1'b0;
		req_compare(is_wr ? req_value(exp_lba, 8'h00, mask) : req_value(exp_lba, mask, 8'h00),
			sd_req);
		status_compare(exp_st, host_status);
		host_ctrl = '0;
		sd_ack = mask;
		step(2);
		req_compare(req_value(exp_lba, 8'h00, 8'h00), sd_req);
		sd_ack = 8'h00;
		wait_io_done();
		exp_st.io_done = 1'b1;
		status_compare(exp_st, host_status);
	endtask

	task automatic request_blocks();
		test_name = "block_req";
		block_request(1'b0, 3'd3);
		block_request(1'b1, 3'd6);
	endtask

	task automatic mount_image(input logic [7:0] slots, input logic ro,
		input logic [1:0] ftype, input logic [31:0] size,
		input logic [2:0] exp_fileno, input logic exp_ro);
		mount.img_mounted = slots;
		mount.readonly = ro;
		mount.filetype = ftype;
		mount.size = size;
		step(2);
		exp_st.mounted = ~exp_st.mounted;
		exp_st.fileno = exp_fileno;
		exp_st.filetype = ftype;
		exp_st.readonly = exp_ro;
		status_compare(exp_st, host_status);
		host_ctrl = '0;
		host_ctrl.lba_sel = 1'b1;
		step();
		word_compare(size, host_rdata);
		host_ctrl = '0;
		mount.img_mounted = 8'h00;
		step(2);
	endtask

	task automatic mount_drives();
		test_name = "mount";
		mount_image(8'h04, 1'b0, 2'd1, $urandom, 3'd2, 1'b0);
		// Slot 5 holds a cartridge image
		mount_image(8'h20, 1'b0, 2'd2, $urandom, 3'd5, 1'b1);
	endtask

	task automatic mouse_packet(input logic [7:0] flags, input logic [7:0] dx,
		input logic [7:0] dy, input logic inv);
		axis_t exp_axis;
		logic [13:0] exp_joy;
		invert_y = inv;
		mouse.toggle = ~mouse.toggle;
		mouse.flags = flags;
		mouse.dx = dx;
		mouse.dy = dy;
		step(2);
		exp_x = clamp_axis(exp_x + movement_step(flags[4], dx));
		if (inv) exp_y = clamp_axis(exp_y - movement_step(flags[5], dy));
		else exp_y = clamp_axis(exp_y + movement_step(flags[5], dy));
		exp_axis.x = 8'(exp_x);
		exp_axis.y = 8'(exp_y);
		exp_joy = joy_in;
		exp_joy[8] = flags[1];
		exp_joy[7] = flags[0];
		axis_compare(exp_axis, axis);
		joy_compare(exp_joy, joy_out);
	endtask

	task automatic emulate_mouse();
		axis_t stick;
		test_name = "mouse";
		joy_in = 14'h2A5A;
		mouse_packet(8'h01, 8'd200, 8'd6, 1'b0);
		mouse_packet(8'h32, 8'h02, 8'hF9, 1'b0);
		// Drive both axes into saturation
		repeat (15) mouse_packet(8'h02, 8'hFF, 8'd100, 1'b1);
		for (int i = 0; i < 20; i++) begin
			mouse_packet(8'($urandom) & 8'h33, 8'($urandom), 8'($urandom), 1'($urandom));
		end
		// Both buttons held when the stick takes over
		mouse_packet(8'h03, 8'd0, 8'd0, 1'b0);
		analog = 16'h9C37;
		stick.x = 8'h37;
		stick.y = 8'h9C;
		step(2);
		axis_compare(stick, axis);
		joy_compare(joy_in, joy_out);
		// Accumulators start again from zero
		analog = 16'h0000;
		exp_x = 0;
		exp_y = 0;
		mouse_packet(8'h03, 8'd8, 8'd8, 1'b0);
		cpu_halt = 1'b1;
		step(2);
		axis_compare('0, axis);
		joy_compare(joy_in, joy_out);
		cpu_halt = 1'b0;
	endtask

	initial begin
		void'($urandom(32'h6b82));
		clk_sys = 1'b0;
		areset = 1'b1;
		host_ctrl = '0;
		host_wdata = '0;
		{data_wr, data_rd, io_wr} = 3'b000;
		mount = '0;
		sd_ack = 8'h00;
		sd_buf_addr = '0;
		sd_buf_wdata = 8'h00;
		sd_buf_we = 1'b0;
		mouse = '0;
		analog = 16'h0000;
		joy_in = 14'h0000;
		{cpu_halt, invert_y} = 2'b00;
		{mismatches, failures, cycles} = '0;
		exp_st = '0;
		exp_lba = '0;
		exp_x = 0;
		exp_y = 0;
		step(5);
		areset = 1'b0;
		step();
		load_lba();
		fill_from_host();
		fill_from_sd();
		request_blocks();
		mount_drives();
		emulate_mouse();
		$display("Closing: %0d mismatches, %0d other errors, %0d assertion failures",
			mismatches, failures, DUT.u_a800_io_chk.assert_fails);
		if (mismatches == 0 && failures == 0 && DUT.u_a800_io_chk.assert_fails == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: project.f
+incdir+source
source/a800_pkg.sv
source/sector_buffer.sv
source/disk_bridge.sv
source/mouse_axis.sv
source/a800_io_top.sv
bench/a800_io_chk.sv
bench/tb_a800_io.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_a800_io
FILELIST = project.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all lint build sim clean

all: sim

# Static checks over the whole file list
lint:
	$(TOOL) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

# Pass only when the log holds the pass line
sim: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
